// File: logic/procyon_core_pkg.sv
// core-wide widths and vector types, imported by every design file and by the testbench.
package procyon_core_pkg;

    // datapath width, fixed by the RV32I ISA.
    localparam int DATA_WIDTH  = 32;

    // width of a reorder-buffer tag, sized for a 64-entry reorder buffer.
    localparam int TAG_WIDTH   = 6;

    // a shift can move at most DATA_WIDTH-1 bit positions.
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

    // plain operand or result as it sits on the common data bus.
    typedef logic [DATA_WIDTH-1:0]         procyon_data_t;

    // the same operand viewed as a two's complement number.
    typedef logic signed [DATA_WIDTH-1:0]  procyon_signed_data_t;

    // byte address of an instruction.
    typedef logic [DATA_WIDTH-1:0]         procyon_addr_t;

    // shift amount taken from the low bits of the second operand.
    typedef logic [SHAMT_WIDTH-1:0]        procyon_shamt_t;

    // names the reorder-buffer entry that owns an operation.
    typedef logic [TAG_WIDTH-1:0]          procyon_tag_t;

endpackage

// File: logic/procyon_ieu_pkg.sv
// encodings and stage-to-stage structs of the integer execution unit, used by its design and testbench.
package procyon_ieu_pkg;

    // the funct3 field of an RV32I instruction.
    typedef logic [2:0] procyon_funct3_t;

    // major opcodes that the integer unit executes.
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } procyon_opcode_t;

    typedef enum logic [3:0] {
        ALU_FUNC_ADD, ALU_FUNC_SUB, ALU_FUNC_AND, ALU_FUNC_OR,
        ALU_FUNC_XOR, ALU_FUNC_SLL, ALU_FUNC_SRL, ALU_FUNC_SRA,
        ALU_FUNC_EQ,  ALU_FUNC_NE,  ALU_FUNC_LT,  ALU_FUNC_LTU,
        ALU_FUNC_GE,  ALU_FUNC_GEU
    } procyon_alu_func_t;

    // one operation as issued by the reservation station.
    typedef struct packed {
        procyon_opcode_t                opcode;
        procyon_funct3_t                funct3;
        logic                           funct7_5; // selects SUB and SRA.
        procyon_core_pkg::procyon_data_t rs1;
        procyon_core_pkg::procyon_data_t rs2;
        procyon_core_pkg::procyon_addr_t iaddr;
        procyon_core_pkg::procyon_data_t imm; // sign-extended by the dispatcher.
        procyon_core_pkg::procyon_tag_t  tag;
    } ieu_issue_t;

    // decoded operation handed from ieu_id to ieu_ex.
    typedef struct packed {
        procyon_alu_func_t               alu_func;
        procyon_core_pkg::procyon_data_t  src_a;
        procyon_core_pkg::procyon_data_t  src_b;
        procyon_core_pkg::procyon_addr_t  iaddr;
        procyon_core_pkg::procyon_data_t  imm_b; // branch offset.
        procyon_core_pkg::procyon_shamt_t shamt;
        procyon_core_pkg::procyon_tag_t   tag;
        logic                            jmp;
        logic                            br;
    } ieu_ex_op_t;

    // what the unit drives onto the common data bus.
    typedef struct packed {
        procyon_core_pkg::procyon_data_t data;
        procyon_core_pkg::procyon_addr_t addr;
        procyon_core_pkg::procyon_tag_t  tag;
        logic                           redirect;
    } ieu_result_t;

endpackage

// File: logic/ieu_id.sv
// decode stage of the integer unit, turning an issued RV32I operation into a registered ALU operation.
`timescale 1ns/10ps

module ieu_id (
    input  logic                        clk,
    input  logic                        n_rst,

    input  logic                        i_flush,

    input  procyon_ieu_pkg::ieu_issue_t i_issue,
    input  logic                        i_valid,

    output procyon_ieu_pkg::ieu_ex_op_t o_op,
    output logic                        o_valid
);

    import procyon_core_pkg::*;
    import procyon_ieu_pkg::*;

    ieu_ex_op_t op_next;

    // register and immediate arithmetic share funct3, only the register form has SUB.
    function automatic procyon_alu_func_t arith_func(
        input procyon_funct3_t funct3,
        input logic            funct7_5,
        input logic            is_reg
    );
        procyon_alu_func_t func;

        case (funct3)
            3'b000:  func = (is_reg & funct7_5) ? ALU_FUNC_SUB : ALU_FUNC_ADD;
            3'b001:  func = ALU_FUNC_SLL;
            3'b010:  func = ALU_FUNC_LT; // slt yields 0 or 1.
            3'b011:  func = ALU_FUNC_LTU;
            3'b100:  func = ALU_FUNC_XOR;
            3'b101:  func = funct7_5 ? ALU_FUNC_SRA : ALU_FUNC_SRL;
            3'b110:  func = ALU_FUNC_OR;
            default: func = ALU_FUNC_AND;
        endcase

        return func;
    endfunction

    function automatic procyon_alu_func_t branch_func(
        input procyon_funct3_t funct3
    );
        procyon_alu_func_t func;

        case (funct3)
            3'b001:  func = ALU_FUNC_NE;
            3'b100:  func = ALU_FUNC_LT;
            3'b101:  func = ALU_FUNC_GE;
            3'b110:  func = ALU_FUNC_LTU;
            3'b111:  func = ALU_FUNC_GEU;
            default: func = ALU_FUNC_EQ; // beq and the two unused encodings.
        endcase

        return func;
    endfunction

    always_comb begin
        op_next.alu_func = ALU_FUNC_ADD;
        op_next.src_a    = '0;
        op_next.src_b    = '0;
        op_next.iaddr    = i_issue.iaddr;
        op_next.imm_b    = i_issue.imm;
        op_next.tag      = i_issue.tag;
        op_next.jmp      = 1'b0;
        op_next.br       = 1'b0;

        case (i_issue.opcode)
            OPCODE_OP: begin
                op_next.alu_func = arith_func(i_issue.funct3, i_issue.funct7_5, 1'b1);
                op_next.src_a    = i_issue.rs1;
                op_next.src_b    = i_issue.rs2;
            end
            OPCODE_OP_IMM: begin
                op_next.alu_func = arith_func(i_issue.funct3, i_issue.funct7_5, 1'b0);
                op_next.src_a    = i_issue.rs1;
                op_next.src_b    = i_issue.imm;
            end
            OPCODE_LUI: begin
                op_next.src_b = i_issue.imm; // added to zero.
            end
            OPCODE_AUIPC: begin
                op_next.src_a = i_issue.iaddr;
                op_next.src_b = i_issue.imm;
            end
            OPCODE_JAL: begin
                op_next.src_a = i_issue.iaddr;
                op_next.src_b = i_issue.imm;
                op_next.jmp   = 1'b1;
            end
            OPCODE_JALR: begin
                op_next.src_a = i_issue.rs1;
                op_next.src_b = i_issue.imm;
                op_next.jmp   = 1'b1;
            end
            OPCODE_BRANCH: begin
                op_next.alu_func = branch_func(i_issue.funct3);
                op_next.src_a    = i_issue.rs1;
                op_next.src_b    = i_issue.rs2;
                op_next.br       = 1'b1;
            end
            default: begin
            end
        endcase

        op_next.shamt = op_next.src_b[SHAMT_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush; // a flush also drops the incoming operation.
        end
    end

    always_ff @(posedge clk) begin
        o_op <= op_next;
    end

    // ieu_ex picks its data and target from jmp first, so a branch must never carry it.
    jmp_br_exclusive: assert property (@(posedge clk) disable iff (~n_rst)
        o_valid |-> ~(o_op.jmp & o_op.br))
        else $error("ieu_id issued an operation flagged as both jump and branch");

endmodule

// File: logic/ieu_ex.sv
// execution stage of the integer unit that computes the result, target and redirect for the data bus.
`timescale 1ns/10ps

module ieu_ex (
    input  logic                         clk,
    input  logic                         n_rst,

    input  logic                         i_flush,

    input  procyon_ieu_pkg::ieu_ex_op_t  i_op,
    input  logic                         i_valid,

    output procyon_ieu_pkg::ieu_result_t o_result,
    output logic                         o_valid
);

    import procyon_core_pkg::*;
    import procyon_ieu_pkg::*;

    localparam procyon_addr_t INSN_BYTES = 4;

    procyon_data_t                result;
    logic [DATA_WIDTH*2-1:0]      e_src_a; // sign copies shift in for sra.
    procyon_signed_data_t         s_src_a;
    procyon_signed_data_t         s_src_b;

    assign e_src_a = {{DATA_WIDTH{i_op.src_a[DATA_WIDTH-1]}}, i_op.src_a};
    assign s_src_a = i_op.src_a;
    assign s_src_b = i_op.src_b;

    always_comb begin
        case (i_op.alu_func)
            ALU_FUNC_ADD: result = i_op.src_a + i_op.src_b;
            ALU_FUNC_SUB: result = i_op.src_a - i_op.src_b;
            ALU_FUNC_AND: result = i_op.src_a & i_op.src_b;
            ALU_FUNC_OR:  result = i_op.src_a | i_op.src_b;
            ALU_FUNC_XOR: result = i_op.src_a ^ i_op.src_b;
            ALU_FUNC_SLL: result = i_op.src_a << i_op.shamt;
            ALU_FUNC_SRL: result = i_op.src_a >> i_op.shamt;
            ALU_FUNC_SRA: result = procyon_data_t'(e_src_a >> i_op.shamt);
            ALU_FUNC_EQ:  result = procyon_data_t'(i_op.src_a == i_op.src_b);
            ALU_FUNC_NE:  result = procyon_data_t'(i_op.src_a != i_op.src_b);
            ALU_FUNC_LT:  result = procyon_data_t'(s_src_a < s_src_b);
            ALU_FUNC_LTU: result = procyon_data_t'(i_op.src_a < i_op.src_b);
            ALU_FUNC_GE:  result = procyon_data_t'(s_src_a >= s_src_b);
            ALU_FUNC_GEU: result = procyon_data_t'(i_op.src_a >= i_op.src_b);
            default:      result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (~n_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid & ~i_flush;
        end
    end

    // a jump writes its link address and sends the ALU sum as target.
    always_ff @(posedge clk) begin
        o_result.data     <= i_op.jmp ? i_op.iaddr + INSN_BYTES : result;
        o_result.addr     <= i_op.jmp ? result : i_op.iaddr + i_op.imm_b;
        o_result.redirect <= i_op.jmp | (i_op.br & result[0]); // taken branches only.
        o_result.tag      <= i_op.tag;
    end

    // nothing in flight may reach the bus once the reorder buffer has flushed.
    flush_kills_output: assert property (@(posedge clk) disable iff (~n_rst)
        (i_flush | $past(i_flush)) |=> ~o_valid)
        else $error("ieu_ex drove a valid result within two cycles of a flush");

endmodule

// File: logic/ieu.sv
// top level of the integer execution unit, placed between a reservation station and the data bus.
`timescale 1ns/10ps

module ieu (
    input  logic                         clk,
    input  logic                         n_rst,

    input  logic                         i_flush,

    input  procyon_ieu_pkg::ieu_issue_t  i_issue,
    input  logic                         i_valid,

    output procyon_ieu_pkg::ieu_result_t o_result,
    output logic                         o_valid
);

    import procyon_ieu_pkg::*;

    ieu_ex_op_t ex_op;
    logic       ex_valid;

    // the flush reaches both stages in the same cycle.
    ieu_id ieu_id_i (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_issue  (i_issue),
        .i_valid  (i_valid),
        .o_op     (ex_op),
        .o_valid  (ex_valid)
    );

    ieu_ex ieu_ex_i (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_op     (ex_op),
        .i_valid  (ex_valid),
        .o_result (o_result),
        .o_valid  (o_valid)
    );

endmodule

// File: tb/ieu_clk_gen.sv
// clock and reset source of the integer unit testbench, instantiated once by its top module.
`timescale 1ns/10ps

module ieu_clk_gen (
    output logic clk,
    output logic n_rst
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    initial begin
        n_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 n_rst = 1'b1; // released off the edge like every other input.
    end

endmodule

// File: tb/ieu_tb_ref.svh
// reference model and random source of the integer unit testbench, included inside its top module.
`ifndef IEU_TB_REF_SVH
`define IEU_TB_REF_SVH

// one queued expectation, with the test that issued it.
typedef struct packed {
    ieu_result_t result;
    logic        addr_defined; // only jumps and branches define a target.
    int          test_id;
} ieu_expected_t;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;

    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

function automatic logic has_target(input procyon_opcode_t opcode);
    return (opcode == OPCODE_JAL) || (opcode == OPCODE_JALR) || (opcode == OPCODE_BRANCH);
endfunction

// RV32I semantics of one issued operation as seen on the data bus.
function automatic ieu_result_t ieu_ref(input ieu_issue_t op);
    ieu_result_t          res;
    procyon_data_t        b;
    procyon_signed_data_t sa;
    procyon_signed_data_t sb;
    logic [4:0]           sh;
    logic                 taken;

    b            = (op.opcode == OPCODE_OP || op.opcode == OPCODE_BRANCH) ? op.rs2 : op.imm;
    sa           = op.rs1;
    sb           = b;
    sh           = b[4:0];
    taken        = 1'b0;
    res.data     = '0;
    res.addr     = op.iaddr + op.imm;
    res.tag      = op.tag;
    res.redirect = 1'b0;

    case (op.opcode)
        OPCODE_OP, OPCODE_OP_IMM: begin
            case (op.funct3)
                3'b000: begin
                    if (op.opcode == OPCODE_OP && op.funct7_5) begin
                        res.data = op.rs1 - b;
                    end else begin
                        res.data = op.rs1 + b; // addi has no subtract form.
                    end
                end
                3'b001:  res.data = op.rs1 << sh;
                3'b010:  res.data = {31'b0, sa < sb};
                3'b011:  res.data = {31'b0, op.rs1 < b};
                3'b100:  res.data = op.rs1 ^ b;
                3'b101: begin
                    if (op.funct7_5) begin
                        res.data = sa >>> sh;
                    end else begin
                        res.data = op.rs1 >> sh;
                    end
                end
                3'b110:  res.data = op.rs1 | b;
                default: res.data = op.rs1 & b;
            endcase
        end
        OPCODE_LUI:   res.data = op.imm;
        OPCODE_AUIPC: res.data = op.iaddr + op.imm;
        OPCODE_JAL, OPCODE_JALR: begin
            res.data     = op.iaddr + 32'd4;
            res.redirect = 1'b1;
            if (op.opcode == OPCODE_JALR) begin
                res.addr = op.rs1 + op.imm; // bit 0 is kept.
            end
        end
        OPCODE_BRANCH: begin
            case (op.funct3)
                3'b001:  taken = op.rs1 != op.rs2;
                3'b100:  taken = sa < sb;
                3'b101:  taken = sa >= sb;
                3'b110:  taken = op.rs1 < op.rs2;
                3'b111:  taken = op.rs1 >= op.rs2;
                default: taken = op.rs1 == op.rs2;
            endcase
            res.data     = {31'b0, taken};
            res.redirect = taken;
        end
        default: begin
        end
    endcase

    return res;
endfunction

function automatic ieu_expected_t expected_for(input ieu_issue_t op, input int test_id);
    ieu_expected_t e;

    e.result       = ieu_ref(op);
    e.addr_defined = has_target(op.opcode);
    e.test_id      = test_id;
    return e;
endfunction

`endif

// File: tb/ieu_tb.sv
// testbench top that drives the integer execution unit and is compiled from the file list as top.
`timescale 1ns/10ps

module ieu_tb;

    import procyon_core_pkg::*;
    import procyon_ieu_pkg::*;

    `include "ieu_tb_ref.svh"

    localparam int RESET_CYCLES = 16;
    localparam int N_ARITH      = 160;
    localparam int N_BRANCH     = 120;
    localparam int N_JUMP       = 80;
    localparam int N_STREAM     = 32;
    localparam int FLUSH_ROUNDS = 3;
    localparam int IDLE_GAP     = 4;
    localparam int STIM_CYCLES  = RESET_CYCLES + N_ARITH + N_BRANCH + N_JUMP + N_STREAM
                                + FLUSH_ROUNDS * 6 + 6 * IDLE_GAP;
    localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES + 100;

    localparam int TEST_RESET  = 0;
    localparam int TEST_ARITH  = 1;
    localparam int TEST_BRANCH = 2;
    localparam int TEST_JUMP   = 3;
    localparam int TEST_STREAM = 4;
    localparam int TEST_FLUSH  = 5;

    logic          clk;
    logic          n_rst;
    logic          i_flush;
    logic          i_valid;
    ieu_issue_t    i_issue;
    ieu_result_t   o_result;
    logic          o_valid;

    logic [31:0]   rng_state = 32'h0db7_2e74;
    procyon_tag_t  next_tag = '0;
    ieu_expected_t exp_q[$];
    int            cur_test = TEST_RESET;
    int            value_errors = 0;
    int            protocol_errors = 0;
    int            results_seen = 0;
    int            expected_outputs = 0;
    int            flushed_total = 0;
    int            cycle_count = 0;

    ieu_clk_gen clk_gen_i (
        .clk   (clk),
        .n_rst (n_rst)
    );

    ieu ieu_i (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_issue  (i_issue),
        .i_valid  (i_valid),
        .o_result (o_result),
        .o_valid  (o_valid)
    );

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            TEST_ARITH:  return "arith";
            TEST_BRANCH: return "branch";
            TEST_JUMP:   return "jump_upper";
            TEST_STREAM: return "stream";
            TEST_FLUSH:  return "flush";
            default:     return "reset";
        endcase
    endfunction

    function automatic ieu_issue_t random_issue(input procyon_opcode_t opcode);
        ieu_issue_t  op;
        logic [31:0] r;

        r           = next_random();
        op.opcode   = opcode;
        op.funct3   = r[2:0];
        op.funct7_5 = r[3];
        op.tag      = r[9:4];
        op.rs1      = next_random();
        op.rs2      = next_random();
        r           = next_random();
        op.imm      = {{20{r[11]}}, r[11:0]};
        r           = next_random();
        op.iaddr    = {r[31:2], 2'b00};
        return op;
    endfunction

    function automatic ieu_issue_t random_arith_op(input int k);
        ieu_issue_t op;

        op = random_issue(k[0] ? OPCODE_OP : OPCODE_OP_IMM);
        if (k % 3 == 0) begin
            op.funct3   = 3'b101; // sra of a negative value.
            op.funct7_5 = 1'b1;
            op.rs1[31]  = 1'b1;
        end
        return op;
    endfunction

    function automatic ieu_issue_t random_branch_op(input int k);
        ieu_issue_t  op;
        logic [31:0] r;

        op = random_issue(OPCODE_BRANCH);
        r  = next_random();
        op.imm = {{19{r[12]}}, r[12:1], 1'b0};
        case (k % 6)
            0:       op.funct3 = 3'b000;
            1:       op.funct3 = 3'b001;
            2:       op.funct3 = 3'b100;
            3:       op.funct3 = 3'b101;
            4:       op.funct3 = 3'b110;
            default: op.funct3 = 3'b111;
        endcase
        if (k % 5 == 0) begin
            op.rs2 = op.rs1;
        end
        return op;
    endfunction

    function automatic ieu_issue_t random_jump_op(input int k);
        ieu_issue_t  op;
        logic [31:0] r;

        r = next_random();
        case (k % 4)
            0: begin
                op     = random_issue(OPCODE_JAL);
                op.imm = {{11{r[20]}}, r[20:1], 1'b0};
            end
            1: op = random_issue(OPCODE_JALR);
            2: begin
                op     = random_issue(OPCODE_LUI);
                op.imm = {r[31:12], 12'b0};
            end
            default: begin
                op     = random_issue(OPCODE_AUIPC);
                op.imm = {r[31:12], 12'b0};
            end
        endcase
        return op;
    endfunction

    // a random mix of every kind with consecutive tags.
    function automatic ieu_issue_t tagged_op(input int k);
        ieu_issue_t  op;
        logic [31:0] r;

        r = next_random();
        case (r[1:0])
            2'b01:   op = random_branch_op(k);
            2'b10:   op = random_jump_op(k);
            default: op = random_arith_op(k);
        endcase
        op.tag   = next_tag;
        next_tag = next_tag + procyon_tag_t'(1);
        return op;
    endfunction

    task automatic issue_op(input ieu_issue_t op, input int test);
        @(posedge clk);
        #1;
        i_issue  = op;
        i_valid  = 1'b1;
        i_flush  = 1'b0;
        cur_test = test;
        expected_outputs++;
    endtask

    task automatic issue_with_flush(input ieu_issue_t op, input int test);
        @(posedge clk);
        #1;
        if (i_valid) begin
            expected_outputs--; // the operation issued one edge earlier is still in flight.
        end
        i_issue  = op;
        i_valid  = 1'b1;
        i_flush  = 1'b1;
        cur_test = test;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            i_valid = 1'b0;
            i_flush = 1'b0;
        end
    endtask

    task automatic check_result(input ieu_expected_t expected, input ieu_result_t actual);
        string name;

        name = test_name(expected.test_id);
        assert (actual.data == expected.result.data) else begin
            value_errors++;
            $display("CHECK FAILED %s data expected %h actual %h", name,
                     expected.result.data, actual.data);
        end
        if (expected.addr_defined) begin
            assert (actual.addr == expected.result.addr) else begin
                value_errors++;
                $display("CHECK FAILED %s addr expected %h actual %h", name,
                         expected.result.addr, actual.addr);
            end
        end
        assert (actual.tag == expected.result.tag) else begin
            value_errors++;
            $display("CHECK FAILED %s tag expected %h actual %h", name,
                     expected.result.tag, actual.tag);
        end
        assert (actual.redirect == expected.result.redirect) else begin
            value_errors++;
            $display("CHECK FAILED %s redirect expected %b actual %b", name,
                     expected.result.redirect, actual.redirect);
        end
    endtask

    task automatic print_counts();
        $display("summary: %0d value errors, %0d protocol errors, %0d results checked, %0d flushed",
                 value_errors, protocol_errors, results_seen, flushed_total);
    endtask

    always @(posedge clk) begin : result_checker
        ieu_expected_t expected;

        if (n_rst !== 1'b1) begin
            assert (o_valid !== 1'b1) else begin
                protocol_errors++;
                $display("o_valid was high while reset was asserted");
            end
        end else begin
            if (o_valid) begin
                assert (exp_q.size() != 0) else begin
                    protocol_errors++;
                    $display("unexpected output with tag %h and no operation outstanding",
                             o_result.tag);
                end
                if (exp_q.size() != 0) begin
                    expected = exp_q.pop_front();
                    check_result(expected, o_result);
                    results_seen++;
                end
            end
            if (i_flush) begin
                flushed_total += exp_q.size(); // whatever is still queued was in flight.
                exp_q.delete();
            end else if (i_valid) begin
                exp_q.push_back(expected_for(i_issue, cur_test));
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            protocol_errors++;
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycle_count, exp_q.size());
            print_counts();
            $display("Regression failed");
            $finish;
        end
    end

    initial begin : stimulus
        i_issue = '0;
        i_valid = 1'b0;
        i_flush = 1'b0;
        wait (n_rst === 1'b1);
        idle_cycles(2); // nothing issued yet, so o_valid must stay low.

        for (int k = 0; k < N_ARITH; k++) begin
            issue_op(random_arith_op(k), TEST_ARITH);
        end
        idle_cycles(IDLE_GAP);
        for (int k = 0; k < N_BRANCH; k++) begin
            issue_op(random_branch_op(k), TEST_BRANCH);
        end
        idle_cycles(IDLE_GAP);
        for (int k = 0; k < N_JUMP; k++) begin
            issue_op(random_jump_op(k), TEST_JUMP);
        end
        idle_cycles(IDLE_GAP);
        for (int k = 0; k < N_STREAM; k++) begin
            issue_op(tagged_op(k), TEST_STREAM);
        end

        for (int round = 0; round < FLUSH_ROUNDS; round++) begin
            for (int j = 0; j < 3; j++) begin
                issue_op(tagged_op(j), TEST_FLUSH);
            end
            issue_with_flush(tagged_op(round), TEST_FLUSH);
            for (int j = 0; j < 2; j++) begin
                issue_op(tagged_op(j), TEST_FLUSH);
            end
        end

        idle_cycles(IDLE_GAP);
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        idle_cycles(IDLE_GAP); // a stray result would show up here.

        assert (results_seen == expected_outputs) else begin
            value_errors++;
            $display("CHECK FAILED result_count expected %0d actual %0d",
                     expected_outputs, results_seen);
        end

        print_counts();
        if (value_errors + protocol_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: procyon_ieu.f
logic/procyon_core_pkg.sv
logic/procyon_ieu_pkg.sv
logic/ieu_id.sv
logic/ieu_ex.sv
logic/ieu.sv
tb/ieu_clk_gen.sv
tb/ieu_tb.sv
+incdir+tb

// File: run_sim.sh
#!/bin/sh
# Builds the integer execution unit testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
MDIR=obj_dir

verilator --binary --timing --assert -f procyon_ieu.f --top-module ieu_tb \
    --Mdir "$MDIR" -o ieu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$MDIR/ieu_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" "$LOG"; then
    exit 1
fi

exit 0
